/* phs_avg_top.f */
+incdir+verilog
verilog/phs_avg_pkg.sv
verilog/prl_gain_bank.sv
verilog/phs_avg_mul.sv
verilog/phs_avg.sv
verilog/phs_err_monitor.sv
verilog/phs_avg_top.sv
tb/phs_avg_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the phase averaging testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f phs_avg_top.f \
	--top-module phs_avg_tb -o phs_avg_sim || exit 1
out=$(./obj_dir/phs_avg_sim) || true
echo "$out"
echo "$out" | grep -qx "NO ERRORS" && exit 0 || exit 1

/* tb/phs_avg_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "phs_avg_config.svh"

module phs_avg_tb import phs_avg_pkg::*; ();

	localparam int HALF_PERIOD = 5;
	localparam int RESET_CYCLES = 16;
	// pairs driven per test, gain writes and padding included
	localparam int T1_PAIRS = 20;
	localparam int T2_PAIRS = 44;
	localparam int T3_PAIRS = 208;
	localparam int T5_PAIRS = 48;
	localparam int T6_PAIRS = 30;
	localparam int TOTAL_CYCLES = 2 * (T1_PAIRS + T2_PAIRS + T3_PAIRS + T5_PAIRS + T6_PAIRS + 8)
		+ 4 * RESET_CYCLES;
	// twice the run length as margin
	localparam int WATCHDOG_NS = 2 * 2 * HALF_PERIOD * TOTAL_CYCLES;
	// test 2 step per pair
	// 1012*1024/512 + 2000*256/512 + (-600)*(-512)/512 + 400*768/512 = 4224, over 32 gives 132
	localparam int STEP_T2 = 132;

	logic clk;
	logic reset;
	iq_sample_t sample;
	gain_wr_t gain_wr;
	logic [`PHS_Z_W-2:0] limit;
	logic alarm_clear;
	phase_err_t phase_err;
	logic alarm;

	// reference model state
	logic signed [`PHS_DWJ-1:0] g_fwd_re;
	logic signed [`PHS_DWJ-1:0] g_fwd_im;
	logic signed [`PHS_DWJ-1:0] g_rev_re;
	logic signed [`PHS_DWJ-1:0] g_rev_im;
	logic signed [`PHS_INTG_W-1:0] model_intg;
	logic signed [`PHS_Z_W-1:0] exp_q[$];
	int exp_cyc_q[$];
	logic model_alarm;
	// results seen while collecting, for the step check
	logic collect;
	logic signed [`PHS_Z_W-1:0] seen_q[$];
	int cycle;
	logic [31:0] rng;
	int pass_count;
	int fail_count;
	int test_num;

	phs_avg_top phs_avg_top_inst (
		.clk         (clk),
		.reset       (reset),
		.sample      (sample),
		.gain_wr     (gain_wr),
		.limit       (limit),
		.alarm_clear (alarm_clear),
		.phase_err   (phase_err),
		.alarm       (alarm)
	);

	initial clk = 1'b0;
	always #HALF_PERIOD clk = ~clk;

	initial cycle = 0;
	always @(posedge clk) cycle <= cycle + 1;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// product shifted right by 9, kept to the product width
	function automatic logic signed [`PHS_MUL_W-1:0] scaled_product(
		input logic signed [`PHS_DWI-1:0] x,
		input logic signed [`PHS_DWJ-1:0] k
	);
		logic signed [`PHS_DWI+`PHS_DWJ-1:0] full;
		logic signed [`PHS_DWI+`PHS_DWJ-1:0] shifted;
		full = x * k;
		shifted = full >>> `PHS_PROD_SHIFT;
		return shifted[`PHS_MUL_W-1:0];
	endfunction

	function automatic logic [`PHS_Z_W-1:0] magnitude(input logic signed [`PHS_Z_W-1:0] v);
		if (v < 0) begin
			return -v;
		end
		return v;
	endfunction

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic next_rand(output logic [31:0] r);
		rng = xorshift32(rng);
		r = rng;
	endtask

	// integrate one pair into the model and queue its result
	task automatic record_pair(input logic signed [`PHS_INTG_W-1:0] contrib);
		logic signed [`PHS_INTG_W-1:0] zs;
		model_intg = model_intg + contrib;
		zs = model_intg >>> `PHS_Z_SHIFT;
		exp_q.push_back(zs[`PHS_Z_W-1:0]);
		// result is due 5 cycles after the imaginary sample
		exp_cyc_q.push_back(cycle + 5);
	endtask

	// real slot meets the imaginary gain, imaginary slot the real gain
	task automatic drive_pair(
		input logic signed [`PHS_DWI-1:0] fr,
		input logic signed [`PHS_DWI-1:0] rr,
		input logic signed [`PHS_DWI-1:0] fi,
		input logic signed [`PHS_DWI-1:0] ri,
		input logic clr
	);
		logic signed [`PHS_INTG_W-1:0] contrib;
		gain_wr = '0;
		sample = '{iq: 1'b1, fwd: fr, rev: rr};
		alarm_clear = clr;
		step();
		sample = '{iq: 1'b0, fwd: fi, rev: ri};
		alarm_clear = 1'b0;
		contrib = scaled_product(fr, g_fwd_im) + scaled_product(rr, g_rev_im)
			+ scaled_product(fi, g_fwd_re) + scaled_product(ri, g_rev_re);
		record_pair(contrib);
		step();
	endtask

	task automatic rand_pair();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] d;
		next_rand(a);
		next_rand(b);
		next_rand(c);
		next_rand(d);
		drive_pair(a[16:0], b[16:0], c[16:0], d[16:0], 1'b0);
	endtask

	// writes happen on zero sample pairs, so the model may switch gains at once
	task automatic set_gains(
		input logic signed [`PHS_DWJ-1:0] fre,
		input logic signed [`PHS_DWJ-1:0] fim,
		input logic signed [`PHS_DWJ-1:0] rre,
		input logic signed [`PHS_DWJ-1:0] rim
	);
		sample = '{iq: 1'b1, fwd: '0, rev: '0};
		gain_wr = '{valid: 1'b1, chan: CHAN_FWD, addr: SLOT_RE, gain: fre};
		step();
		sample.iq = 1'b0;
		gain_wr = '{valid: 1'b1, chan: CHAN_FWD, addr: SLOT_IM, gain: fim};
		record_pair('0);
		step();
		sample.iq = 1'b1;
		gain_wr = '{valid: 1'b1, chan: CHAN_REV, addr: SLOT_RE, gain: rre};
		step();
		sample.iq = 1'b0;
		gain_wr = '{valid: 1'b1, chan: CHAN_REV, addr: SLOT_IM, gain: rim};
		record_pair('0);
		step();
		g_fwd_re = fre;
		g_fwd_im = fim;
		g_rev_re = rre;
		g_rev_im = rim;
		// zero pairs so the new gains settle in the pipeline
		drive_pair('0, '0, '0, '0, 1'b0);
		drive_pair('0, '0, '0, '0, 1'b0);
	endtask

	// results still in flight are dropped together with the model
	task automatic apply_reset();
		reset = 1'b1;
		sample = '{iq: 1'b1, fwd: '0, rev: '0};
		gain_wr = '0;
		alarm_clear = 1'b0;
		repeat (RESET_CYCLES) step();
		exp_q.delete();
		exp_cyc_q.delete();
		model_intg = '0;
		g_fwd_re = '0;
		g_fwd_im = '0;
		g_rev_re = '0;
		g_rev_im = '0;
		reset = 1'b0;
	endtask

	task automatic finish_test(input string name);
		$display("test %0d %s finished, failures so far %0d", test_num, name, fail_count);
		test_num++;
	endtask

	// valid is a single cycle pulse
	assert property (@(posedge clk) disable iff (reset) phase_err.valid |=> !phase_err.valid)
	else begin
		$display("valid pulse on two adjacent cycles at cycle %0d", cycle);
		fail_count++;
	end

	// outputs are stable at the falling edge
	always @(negedge clk) begin
		logic signed [`PHS_Z_W-1:0] exp_v;
		int exp_c;
		logic over;
		over = 1'b0;
		if (reset) begin
			model_alarm = 1'b0;
		end else begin
			assert (alarm == model_alarm) pass_count++;
			else begin
				$display("MISMATCH alarm expected %h actual %h", model_alarm, alarm);
				fail_count++;
			end
			if (phase_err.valid) begin
				if (exp_q.size() == 0) begin
					$display("valid pulse at cycle %0d with no pair outstanding", cycle);
					fail_count++;
				end else begin
					exp_v = exp_q.pop_front();
					exp_c = exp_cyc_q.pop_front();
					assert (phase_err.value == exp_v) pass_count++;
					else begin
						$display("MISMATCH phase_err.value expected %h actual %h",
							exp_v, phase_err.value);
						fail_count++;
					end
					assert (cycle == exp_c) pass_count++;
					else begin
						$display("result arrived at cycle %0d, expected at cycle %0d",
							cycle, exp_c);
						fail_count++;
					end
					if (collect) begin
						seen_q.push_back(phase_err.value);
					end
					over = magnitude(exp_v) > {1'b0, limit};
				end
			end
			// setting wins over clearing
			if (over) begin
				model_alarm = 1'b1;
			end else if (alarm_clear) begin
				model_alarm = 1'b0;
			end
		end
	end

	initial begin
		#WATCHDOG_NS;
		$display("watchdog expired, the run did not finish in %0d ns", WATCHDOG_NS);
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		logic [31:0] r;
		int k;
		reset = 1'b1;
		sample = '{iq: 1'b1, fwd: '0, rev: '0};
		gain_wr = '0;
		// limit zero so any nonzero result would raise the alarm
		limit = '0;
		alarm_clear = 1'b0;
		model_intg = '0;
		model_alarm = 1'b0;
		collect = 1'b0;
		rng = 32'd59261;
		pass_count = 0;
		fail_count = 0;
		test_num = 1;
		apply_reset();

		// gains still zero, every result zero
		repeat (T1_PAIRS) rand_pair();
		assert (alarm == 1'b0) pass_count++;
		else begin
			$display("alarm rose with all gains at zero");
			fail_count++;
		end
		finish_test("zero gains");

		// fixed gains, constant samples, constant step
		limit = '1;
		collect = 1'b1;
		set_gains(-16'sd512, 16'sd1024, 16'sd768, 16'sd256);
		repeat (T2_PAIRS - 4) drive_pair(17'sd1012, 17'sd2000, -17'sd600, 17'sd400, 1'b0);
		collect = 1'b0;
		k = 0;
		foreach (seen_q[i]) begin
			if (seen_q[i] != 0) begin
				k++;
				assert (seen_q[i] == STEP_T2 * k) pass_count++;
				else begin
					$display("MISMATCH phase_err.value expected %h actual %h",
						STEP_T2 * k, seen_q[i]);
					fail_count++;
				end
			end
		end
		assert (k >= T2_PAIRS - 8) pass_count++;
		else begin
			$display("only %0d growing results seen in the constant sample test", k);
			fail_count++;
		end
		finish_test("constant gain");

		// random gains written on zero samples, then random samples
		repeat (2) begin
			next_rand(r);
			set_gains(r[15:0], r[31:16], r[31:16] ^ r[15:0], r[23:8]);
			repeat (T3_PAIRS / 2 - 4) rand_pair();
		end
		finish_test("random gains and samples");
		// pulse spacing is checked on every result by the arrival cycle
		finish_test("valid spacing");

		// sticky alarm, limit 45 on a ramp of 10 per pair
		apply_reset();
		limit = 18'd45;
		set_gains('0, 16'sd512, '0, '0);
		repeat (5) drive_pair(17'sd320, '0, '0, '0, 1'b0);
		repeat (4) drive_pair(-17'sd320, '0, '0, '0, 1'b0);
		repeat (6) drive_pair('0, '0, '0, '0, 1'b0);
		assert (alarm == 1'b1) pass_count++;
		else begin
			$display("alarm did not stay set after the result fell under limit");
			fail_count++;
		end
		drive_pair('0, '0, '0, '0, 1'b1);
		repeat (3) drive_pair('0, '0, '0, '0, 1'b0);
		assert (alarm == 1'b0) pass_count++;
		else begin
			$display("alarm_clear did not drop the alarm");
			fail_count++;
		end
		// clear on the eighth pair meets an over limit result
		repeat (7) drive_pair(17'sd320, '0, '0, '0, 1'b0);
		drive_pair(17'sd320, '0, '0, '0, 1'b1);
		repeat (4) drive_pair('0, '0, '0, '0, 1'b0);
		assert (alarm == 1'b1) pass_count++;
		else begin
			$display("alarm_clear won against an over limit result");
			fail_count++;
		end
		finish_test("sticky alarm");

		// mid run reset with the integrator loaded
		limit = '1;
		next_rand(r);
		set_gains(r[15:0], r[31:16], r[23:8], r[15:0]);
		repeat (6) rand_pair();
		apply_reset();
		repeat (T6_PAIRS - 10) rand_pair();
		repeat (4) drive_pair('0, '0, '0, '0, 1'b0);
		// keep the slots alternating while the last results drain
		k = 0;
		while (exp_q.size() != 0 && k < 8) begin
			sample.iq = ~sample.iq;
			step();
			k++;
		end
		assert (exp_q.size() == 0) pass_count++;
		else begin
			$display("%0d results never arrived", exp_q.size());
			fail_count++;
		end
		finish_test("reset mid run");

		reset = 1'b1;
		repeat (3) step();
		$display("checks passed %0d failed %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/phs_avg.sv */
`timescale 1ns/1ps
`default_nettype none

`include "phs_avg_config.svh"

// phase averaging datapath
// forward times gain plus reverse times gain, imaginary part only
// with interleaved data the imaginary part of (a + ib)(c + id) is a*d + b*c
// so the real sample meets the imaginary gain and the reverse as well
// one multiplier per stream then covers both cross terms
// the per cycle sum is integrated and scaled down into z
module phs_avg import phs_avg_pkg::*; (
	input wire clk,
	input wire reset,
	input wire iq_sample_t sample,
	output logic gain_addr,
	input wire gain_pair_t gains,
	output logic signed [`PHS_Z_W-1:0] z,
	output logic z_done
);

	// input register
	iq_sample_t s_r;
	// products, one cycle after s_r
	logic signed [`PHS_MUL_W-1:0] fwd_p;
	logic signed [`PHS_MUL_W-1:0] rev_p;
	// sum of both products, one extra bit
	logic signed [`PHS_MUL_W:0] sum;
	logic signed [`PHS_INTG_W-1:0] intg;
	// imaginary slot marker, aligned with product, sum and integrator
	logic [2:0] imag_pipe;

	// reset leaves a real slot in the input register
	// so no pair end is flagged until real data arrives
	always_ff @(posedge clk) begin
		if (reset) begin
			s_r <= '{iq: 1'b1, default: '0};
		end else begin
			s_r <= sample;
		end
	end

	// bank read follows the slot entering the datapath
	assign gain_addr = s_r.iq;

	phs_avg_mul fwd_mul (
		.clk (clk),
		.x   (s_r.fwd),
		.k   (gains.fwd),
		.p   (fwd_p)
	);

	phs_avg_mul rev_mul (
		.clk (clk),
		.x   (s_r.rev),
		.k   (gains.rev),
		.p   (rev_p)
	);

	// sum then integrate
	// two cycles of the sum make one imaginary cross term pair
	always_ff @(posedge clk) begin
		if (reset) begin
			sum <= '0;
			intg <= '0;
		end else begin
			sum <= fwd_p + rev_p;
			intg <= intg + sum;
		end
	end

	// iq copy tracking the product, the sum and the integrator
	always_ff @(posedge clk) begin
		if (reset) begin
			imag_pipe <= '0;
		end else begin
			imag_pipe <= {imag_pipe[1:0], ~s_r.iq};
		end
	end

	// high for one cycle once the imaginary slot is in the integrator
	assign z_done = imag_pipe[2];

	// scaled integrator, top guard bit dropped
	assign z = intg[`PHS_Z_SHIFT +: `PHS_Z_W];

endmodule

`default_nettype wire

/* verilog/phs_avg_config.svh */
`ifndef PHS_AVG_CONFIG_SVH
`define PHS_AVG_CONFIG_SVH

// width of one downconverted sample
`define PHS_DWI 17
// width of one host gain word
`define PHS_DWJ 16

// full product is shifted down by sample width minus 8
`define PHS_PROD_SHIFT 9
// kept product bits, sample width plus 6
`define PHS_MUL_W 23

// integrator has 8 guard bits over the sample
`define PHS_INTG_W 25
// integrator to phase error scaling
`define PHS_Z_SHIFT 5
// phase error word, sample width plus 2
`define PHS_Z_W 19

`endif

/* verilog/phs_avg_mul.sv */
`timescale 1ns/1ps
`default_nettype none

`include "phs_avg_config.svh"

// one interleaved stream times its gain word
// the gain is delayed one cycle so that with the registered bank read
// a sample in slot iq meets the gain stored at address iq
module phs_avg_mul (
	input wire clk,
	input wire signed [`PHS_DWI-1:0] x,
	input wire signed [`PHS_DWJ-1:0] k,
	output logic signed [`PHS_MUL_W-1:0] p
);

	// gain word, one cycle behind the bank output
	logic signed [`PHS_DWJ-1:0] k_d;
	// full width signed product
	logic signed [`PHS_DWI+`PHS_DWJ-1:0] prod;

	always_ff @(posedge clk) begin
		k_d <= k;
		prod <= x * k_d;
	end

	// drop the low fraction bits and the redundant sign bit
	assign p = prod[`PHS_PROD_SHIFT +: `PHS_MUL_W];

endmodule

`default_nettype wire

/* verilog/phs_avg_pkg.sv */
`default_nettype none

`include "phs_avg_config.svh"

package phs_avg_pkg;

	// host channel select values
	localparam logic CHAN_FWD = 1'b0;
	localparam logic CHAN_REV = 1'b1;

	// gain slot addresses
	localparam logic SLOT_RE = 1'b0;
	localparam logic SLOT_IM = 1'b1;

	// one interleaved input cycle
	// iq high marks the real slot
	typedef struct packed {
		logic iq;
		logic signed [`PHS_DWI-1:0] fwd;
		logic signed [`PHS_DWI-1:0] rev;
	} iq_sample_t;

	// one host write into the gain bank
	typedef struct packed {
		logic valid;
		logic chan;
		logic addr;
		logic signed [`PHS_DWJ-1:0] gain;
	} gain_wr_t;

	// forward and reverse gain words for one slot
	typedef struct packed {
		logic signed [`PHS_DWJ-1:0] fwd;
		logic signed [`PHS_DWJ-1:0] rev;
	} gain_pair_t;

	// one phase error result, valid for a single cycle
	typedef struct packed {
		logic valid;
		logic signed [`PHS_Z_W-1:0] value;
	} phase_err_t;

endpackage

`default_nettype wire

/* verilog/phs_avg_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "phs_avg_config.svh"

// phase averaging path
// gain bank, averager and result monitor
// a result appears five cycles after the imaginary sample of its pair
module phs_avg_top import phs_avg_pkg::*; (
	input wire clk,
	input wire reset,
	// interleaved forward and reverse samples, real slot first
	input wire iq_sample_t sample,
	// host gain write strobe
	input wire gain_wr_t gain_wr,
	// alarm threshold on the result magnitude
	input wire [`PHS_Z_W-2:0] limit,
	input wire alarm_clear,
	output phase_err_t phase_err,
	output logic alarm
);

	// bank read address from the averager
	logic gain_addr;
	// gain words for the current slot
	gain_pair_t gains;
	// scaled integrator and pair end strobe
	logic signed [`PHS_Z_W-1:0] z;
	logic z_done;

	prl_gain_bank gain_bank_inst (
		.clk     (clk),
		.reset   (reset),
		.gain_wr (gain_wr),
		.addr    (gain_addr),
		.gains   (gains)
	);

	phs_avg phs_avg_inst (
		.clk       (clk),
		.reset     (reset),
		.sample    (sample),
		.gain_addr (gain_addr),
		.gains     (gains),
		.z         (z),
		.z_done    (z_done)
	);

	phs_err_monitor monitor_inst (
		.clk         (clk),
		.reset       (reset),
		.z           (z),
		.z_done      (z_done),
		.limit       (limit),
		.alarm_clear (alarm_clear),
		.phase_err   (phase_err),
		.alarm       (alarm)
	);

endmodule

`default_nettype wire

/* verilog/phs_err_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

`include "phs_avg_config.svh"

// captures one phase error per pair and raises the sticky alarm
module phs_err_monitor import phs_avg_pkg::*; (
	input wire clk,
	input wire reset,
	input wire signed [`PHS_Z_W-1:0] z,
	input wire z_done,
	input wire [`PHS_Z_W-2:0] limit,
	input wire alarm_clear,
	output phase_err_t phase_err,
	output logic alarm
);

	// captured result
	logic signed [`PHS_Z_W-1:0] z_cap;
	logic valid_r;
	// magnitude of the captured result
	// most negative value maps to 2**(Z_W-1) and still fits
	logic [`PHS_Z_W-1:0] mag;
	logic over;

	// result capture
	always_ff @(posedge clk) begin
		if (z_done) begin
			z_cap <= z;
		end
	end

	// valid is one cycle behind z_done
	always_ff @(posedge clk) begin
		if (reset) begin
			valid_r <= 1'b0;
		end else begin
			valid_r <= z_done;
		end
	end

	assign phase_err.valid = valid_r;
	assign phase_err.value = z_cap;

	// two's complement magnitude
	always_comb begin
		if (z_cap[`PHS_Z_W-1]) begin
			mag = ~z_cap + 1'b1;
		end else begin
			mag = z_cap;
		end
	end

	// only a valid result can trip the alarm
	assign over = valid_r && (mag > {1'b0, limit});

	// sticky alarm
	// a result over limit wins against a clear in the same cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			alarm <= 1'b0;
		end else if (over) begin
			alarm <= 1'b1;
		end else if (alarm_clear) begin
			alarm <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* verilog/prl_gain_bank.sv */
`timescale 1ns/1ps
`default_nettype none

`include "phs_avg_config.svh"

// host programmable complex gains for forward and reverse
// address 0 is the real part and address 1 the imaginary part
module prl_gain_bank import phs_avg_pkg::*; (
	input wire clk,
	input wire reset,
	input wire gain_wr_t gain_wr,
	input wire addr,
	output gain_pair_t gains
);

	// forward gain parts
	logic signed [`PHS_DWJ-1:0] fwd_re;
	logic signed [`PHS_DWJ-1:0] fwd_im;
	// reverse gain parts
	logic signed [`PHS_DWJ-1:0] rev_re;
	logic signed [`PHS_DWJ-1:0] rev_im;

	// host write port
	// a write is visible from the next edge on
	always_ff @(posedge clk) begin
		if (reset) begin
			fwd_re <= '0;
			fwd_im <= '0;
			rev_re <= '0;
			rev_im <= '0;
		end else if (gain_wr.valid) begin
			if (gain_wr.chan == CHAN_FWD) begin
				if (gain_wr.addr == SLOT_RE) begin
					fwd_re <= gain_wr.gain;
				end else begin
					fwd_im <= gain_wr.gain;
				end
			end else begin
				// CHAN_REV
				if (gain_wr.addr == SLOT_RE) begin
					rev_re <= gain_wr.gain;
				end else begin
					rev_im <= gain_wr.gain;
				end
			end
		end
	end

	// registered read, one cycle from addr to gains
	// both channels share the slot address
	always_ff @(posedge clk) begin
		if (reset) begin
			gains <= '0;
		end else if (addr == SLOT_IM) begin
			gains.fwd <= fwd_im;
			gains.rev <= rev_im;
		end else begin
			gains.fwd <= fwd_re;
			gains.rev <= rev_re;
		end
	end

endmodule

`default_nettype wire
